// ==== rtl/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address and instruction word
`define ICACHE_ADDR_W 64
`define ICACHE_WORD_W 64

// two ways of 64 sets, 32-byte lines
`define ICACHE_SETS 64
`define ICACHE_WORDS 4

// word select inside a line, addr[4:3]
`define ICACHE_WOFF_LO 3

// set index, addr[10:5]
`define ICACHE_IDX_LO 5
`define ICACHE_IDX_HI 10

// tag, addr[63:11]
`define ICACHE_TAG_LO 11

`endif

// ==== rtl/icache_pkg.sv ====
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // instruction word, also one DRAM beat
  typedef logic [`ICACHE_WORD_W-1:0] word_t;

  typedef logic [`ICACHE_ADDR_W-`ICACHE_TAG_LO-1:0] tag_t;

  typedef logic [`ICACHE_IDX_HI-`ICACHE_IDX_LO:0] index_t;

  // word 0 sits in the low bits
  typedef logic [`ICACHE_WORDS*`ICACHE_WORD_W-1:0] line_t;

  typedef logic way_t;

endpackage

`default_nettype wire

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_array (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   lookup_en,
  input  icache_pkg::index_t    lookup_index,
  input  wire                   touch,
  input  icache_pkg::way_t      hit_way,
  input  wire                   fill,
  input  icache_pkg::index_t    fill_index,
  input  icache_pkg::tag_t      fill_tag,
  output logic                  valid0,
  output logic                  valid1,
  output icache_pkg::tag_t      tag0,
  output icache_pkg::tag_t      tag1,
  output icache_pkg::way_t      victim_way
);

  logic [`ICACHE_SETS-1:0] valid0_r;
  logic [`ICACHE_SETS-1:0] valid1_r;
  // per set: the way to replace next
  logic [`ICACHE_SETS-1:0] lru_r;

  icache_pkg::tag_t   tag0_mem [`ICACHE_SETS];
  icache_pkg::tag_t   tag1_mem [`ICACHE_SETS];
  icache_pkg::index_t read_index_q;

  // empty way first, way 0 before way 1
  assign victim_way = !valid0_r[fill_index] ? 1'b0 :
                      !valid1_r[fill_index] ? 1'b1 :
                      lru_r[fill_index];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid0_r <= '0;
      valid1_r <= '0;
      lru_r    <= '0;
      valid0   <= 1'b0;
      valid1   <= 1'b0;
    end else begin
      if (fill) begin
        if (victim_way) begin
          valid1_r[fill_index] <= 1'b1;
        end else begin
          valid0_r[fill_index] <= 1'b1;
        end
        lru_r[fill_index] <= ~victim_way;
      end else if (touch) begin
        // touch refers to the set read last
        lru_r[read_index_q] <= ~hit_way;
      end
      if (lookup_en) begin
        valid0 <= valid0_r[lookup_index];
        valid1 <= valid1_r[lookup_index];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      if (victim_way) begin
        tag1_mem[fill_index] <= fill_tag;
      end else begin
        tag0_mem[fill_index] <= fill_tag;
      end
    end
    if (lookup_en) begin
      tag0         <= tag0_mem[lookup_index];
      tag1         <= tag1_mem[lookup_index];
      read_index_q <= lookup_index;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_data_array (
  input  wire                   clk,
  input  wire                   lookup_en,
  input  icache_pkg::index_t    lookup_index,
  input  wire                   fill,
  input  icache_pkg::index_t    fill_index,
  input  icache_pkg::way_t      fill_way,
  input  icache_pkg::line_t     fill_line,
  output icache_pkg::line_t     line0,
  output icache_pkg::line_t     line1
);

  icache_pkg::line_t way0_mem [`ICACHE_SETS];
  icache_pkg::line_t way1_mem [`ICACHE_SETS];

  // whole line written at once
  always_ff @(posedge clk) begin
    if (fill && !fill_way) begin
      way0_mem[fill_index] <= fill_line;
    end
    if (fill && fill_way) begin
      way1_mem[fill_index] <= fill_line;
    end
  end

  // both ways read together, tag compare picks one
  always_ff @(posedge clk) begin
    if (lookup_en) begin
      line0 <= way0_mem[lookup_index];
      line1 <= way1_mem[lookup_index];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_refill (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   start,
  input  icache_pkg::word_t     dram_data,
  input  wire                   dram_val,
  output logic                  dram_req,
  output logic                  line_done,
  output icache_pkg::line_t     refill_line
);

  localparam int CNT_W = $clog2(`ICACHE_WORDS);

  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;

  assign last_beat = dram_val && (beat_cnt == CNT_W'(`ICACHE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dram_req  <= 1'b0;
      line_done <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      line_done <= last_beat;
      if (last_beat) begin
        dram_req <= 1'b0;
        beat_cnt <= '0;
      end else begin
        if (start) begin
          dram_req <= 1'b1;
        end
        if (dram_val) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // new beat enters at the top, first beat ends up as word 0
  always_ff @(posedge clk) begin
    if (dram_val) begin
      refill_line <= {dram_data,
                      refill_line[`ICACHE_WORDS*`ICACHE_WORD_W-1:`ICACHE_WORD_W]};
    end
  end

  a_val_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    dram_val |-> dram_req
  ) else $error("dram_val without an open DRAM request");

endmodule

`default_nettype wire

// ==== rtl/i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module i_cache (
  input  wire                   clk,
  input  wire                   rst_n,
  // cpu side
  input  icache_pkg::addr_t     cpu_addr,
  input  wire                   ins_req,
  output icache_pkg::word_t     instruction,
  output logic                  rom_abort,
  // dram side
  input  icache_pkg::word_t     dram_data,
  input  wire                   dram_val,
  output logic                  dram_req,
  output icache_pkg::addr_t     dram_req_addr
);

  typedef enum logic [1:0] {
    S_RUN,
    S_MISS,
    S_FILL,
    S_RELOOK
  } state_t;

  state_t             state;
  logic               req_q;
  icache_pkg::addr_t  addr_q;

  logic               valid0;
  logic               valid1;
  icache_pkg::tag_t   tag0;
  icache_pkg::tag_t   tag1;
  icache_pkg::way_t   victim_way;
  icache_pkg::line_t  line0;
  icache_pkg::line_t  line1;
  icache_pkg::line_t  refill_line;
  icache_pkg::line_t  hit_line;
  icache_pkg::tag_t   req_tag;
  icache_pkg::index_t req_index;
  icache_pkg::index_t lookup_index;
  logic               line_done;
  logic               hit0;
  logic               hit1;
  logic               hit;
  logic               miss;
  logic               accept;
  logic               relook;
  logic               lookup_en;
  logic               touch;
  logic               start;

  assign req_tag   = addr_q[`ICACHE_ADDR_W-1:`ICACHE_TAG_LO];
  assign req_index = addr_q[`ICACHE_IDX_HI:`ICACHE_IDX_LO];

  assign hit0 = valid0 && (tag0 == req_tag);
  assign hit1 = valid1 && (tag1 == req_tag);
  assign hit  = hit0 || hit1;
  assign miss = (state == S_RUN) && req_q && !hit;

  // abort covers the miss cycle and the whole refill
  assign rom_abort = miss || (state != S_RUN);

  assign accept = (state == S_RUN) && !miss && ins_req;
  assign relook = (state == S_RELOOK);
  assign touch  = (state == S_RUN) && req_q && hit;
  assign start  = (state == S_MISS);

  // re-read after refill uses the held address
  assign lookup_en    = accept || relook;
  assign lookup_index = relook ? req_index : cpu_addr[`ICACHE_IDX_HI:`ICACHE_IDX_LO];

  assign hit_line    = hit1 ? line1 : line0;
  assign instruction = hit_line[{addr_q[`ICACHE_IDX_LO-1:`ICACHE_WOFF_LO], 6'b0} +: 64];

  assign dram_req_addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_IDX_LO], {`ICACHE_IDX_LO{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_RUN;
      req_q <= 1'b0;
    end else begin
      case (state)
        S_RUN: begin
          if (miss) begin
            state <= S_MISS;
          end else begin
            req_q <= ins_req;
          end
        end
        S_MISS:   state <= S_FILL;
        S_FILL: begin
          if (line_done) begin
            state <= S_RELOOK;
          end
        end
        S_RELOOK: state <= S_RUN;
        default:  state <= S_RUN;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= cpu_addr;
    end
  end

  icache_tag_array u_tag_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_en    (lookup_en),
    .lookup_index (lookup_index),
    .touch        (touch),
    .hit_way      (hit1),
    .fill         (line_done),
    .fill_index   (req_index),
    .fill_tag     (req_tag),
    .valid0       (valid0),
    .valid1       (valid1),
    .tag0         (tag0),
    .tag1         (tag1),
    .victim_way   (victim_way)
  );

  icache_data_array u_data_array (
    .clk          (clk),
    .lookup_en    (lookup_en),
    .lookup_index (lookup_index),
    .fill         (line_done),
    .fill_index   (req_index),
    .fill_way     (victim_way),
    .fill_line    (refill_line),
    .line0        (line0),
    .line1        (line1)
  );

  icache_refill u_refill (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .dram_data    (dram_data),
    .dram_val     (dram_val),
    .dram_req     (dram_req),
    .line_done    (line_done),
    .refill_line  (refill_line)
  );

  a_one_refill: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> !dram_req && !line_done
  ) else $error("new DRAM request while a refill is in progress");

  a_single_hit: assert property (
    @(posedge clk) disable iff (!rst_n)
    req_q |-> !(hit0 && hit1)
  ) else $error("same tag resident in both ways");

endmodule

`default_nettype wire

// ==== testbench/dram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_model #(
  parameter int          DELAY    = 3,
  parameter logic [63:0] PAT_MULT = 64'h1,
  parameter logic [63:0] PAT_XOR  = 64'h0
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                dram_req,
  input  icache_pkg::addr_t  dram_req_addr,
  output icache_pkg::word_t  dram_data,
  output logic               dram_val
);

  icache_pkg::addr_t line_addr;

  initial begin
    dram_val  = 1'b0;
    dram_data = '0;
    forever begin
      @(negedge clk);
      if (rst_n && dram_req) begin
        line_addr = dram_req_addr;
        repeat (DELAY) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
          // one idle cycle between beats 1 and 2
          if (k == 2) begin
            dram_val = 1'b0;
            @(negedge clk);
          end
          dram_val  = 1'b1;
          dram_data = ((line_addr + 64'(8 * k)) * PAT_MULT) ^ PAT_XOR;
          @(negedge clk);
        end
        dram_val = 1'b0;
        // request falls together with line_done
        while (dram_req) @(negedge clk);
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_i_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tb_i_cache;

  localparam int          DRAM_DELAY     = 3;
  localparam logic [63:0] PAT_MULT       = 64'h9e37_79b9_7f4a_7c15;
  localparam logic [63:0] PAT_XOR        = 64'h0f1e_2d3c_4b5a_6978;
  localparam int          ACCESSES       = 226;
  localparam int          TIMEOUT_CYCLES = 20 * ACCESSES + 64;

  logic              clk;
  logic              rst_n;
  logic              ins_req;
  icache_pkg::addr_t cpu_addr;
  icache_pkg::word_t instruction;
  logic              rom_abort;
  icache_pkg::word_t dram_data;
  logic              dram_val;
  logic              dram_req;
  icache_pkg::addr_t dram_req_addr;

  // issued at a falling edge and pending once the cache took it
  icache_pkg::addr_t issued[$];
  icache_pkg::addr_t pending[$];
  icache_pkg::addr_t done_addr;
  icache_pkg::tag_t  sh_tag [2][`ICACHE_SETS];
  logic              sh_valid [2][`ICACHE_SETS];
  logic              sh_lru [`ICACHE_SETS];
  logic              dram_req_q;
  string             test_name;
  int                err_count;
  int                check_count;
  int                test_count;
  int                test_errs;
  int                dram_rises;
  int                shadow_misses;
  int                cycle_cnt;
  int                seed;
  int                r;

  i_cache u_i_cache (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_addr      (cpu_addr),
    .ins_req       (ins_req),
    .instruction   (instruction),
    .rom_abort     (rom_abort),
    .dram_data     (dram_data),
    .dram_val      (dram_val),
    .dram_req      (dram_req),
    .dram_req_addr (dram_req_addr)
  );

  dram_model #(.DELAY(DRAM_DELAY), .PAT_MULT(PAT_MULT), .PAT_XOR(PAT_XOR)) u_dram (
    .clk           (clk),
    .rst_n         (rst_n),
    .dram_req      (dram_req),
    .dram_req_addr (dram_req_addr),
    .dram_data     (dram_data),
    .dram_val      (dram_val)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout after %0d cycles, the cache stopped answering", cycle_cnt);
    $display("Errors found");
    $finish;
  end

  // the word DRAM holds at the word-aligned address
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
    icache_pkg::addr_t base;
    base = addr & ~64'h7;
    return (base * PAT_MULT) ^ PAT_XOR;
  endfunction

  function automatic icache_pkg::addr_t make_addr(input logic [52:0] tag, input int index,
                                                  input int word);
    return (64'(tag) << `ICACHE_TAG_LO) | (64'(index) << `ICACHE_IDX_LO) |
           (64'(word) << `ICACHE_WOFF_LO);
  endfunction

  // returns 1 on a predicted miss and updates tags and lru
  function automatic logic shadow_access(input icache_pkg::addr_t addr);
    icache_pkg::tag_t tag;
    int idx;
    int way;
    tag = addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LO];
    idx = addr[`ICACHE_IDX_HI:`ICACHE_IDX_LO];
    for (way = 0; way < 2; way++) begin
      if (sh_valid[way][idx] && sh_tag[way][idx] == tag) begin
        sh_lru[idx] = (way == 0);
        return 1'b0;
      end
    end
    way = !sh_valid[0][idx] ? 0 : !sh_valid[1][idx] ? 1 : int'(sh_lru[idx]);
    sh_valid[way][idx] = 1'b1;
    sh_tag[way][idx]   = tag;
    sh_lru[idx]        = (way == 0);
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      err_count = err_count + 1;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // call at a falling edge with rom_abort low
  task automatic fetch(input icache_pkg::addr_t addr);
    logic predicted_miss;
    ins_req  = 1'b1;
    cpu_addr = addr;
    issued.push_back(addr);
    predicted_miss = shadow_access(addr);
    if (predicted_miss) begin
      shadow_misses = shadow_misses + 1;
    end
    @(posedge clk);
    @(negedge clk);
    // hit answers in one cycle and a miss holds the requester
    check_value($sformatf("%s rom_abort", test_name), 64'(predicted_miss),
                64'(rom_abort));
    while (rom_abort) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_errs     = err_count;
    dram_rises    = 0;
    shadow_misses = 0;
    test_count    = test_count + 1;
  endtask

  task automatic finish_test();
    ins_req = 1'b0;
    while (pending.size() != 0 || issued.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    check_value($sformatf("%s misses", test_name), shadow_misses, dram_rises);
    test_errs = err_count - test_errs;
    $display("%s: %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed", test_errs);
  endtask

  always @(posedge clk) begin
    if (issued.size() > 0) begin
      pending.push_back(issued.pop_front());
    end
  end

  // answer is due in the first cycle with rom_abort low
  always @(negedge clk) begin
    if (rst_n && pending.size() > 0 && !rom_abort) begin
      done_addr = pending.pop_front();
      check_value(test_name, expected_word(done_addr), instruction);
    end
  end

  always @(negedge clk) begin
    if (rst_n && dram_req && !dram_req_q) begin
      dram_rises = dram_rises + 1;
      if (pending.size() == 0) begin
        err_count = err_count + 1;
        $display("%s: dram_req rose with no fetch outstanding", test_name);
      end else begin
        check_value($sformatf("%s dram_req_addr", test_name), pending[0] & ~64'h1f,
                    dram_req_addr);
      end
    end
    dram_req_q = dram_req;
  end

  initial begin
    seed        = 30782;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    test_name   = "reset";
    dram_req_q  = 1'b0;
    rst_n       = 1'b0;
    ins_req     = 1'b0;
    cpu_addr    = '0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      sh_valid[0][s] = 1'b0;
      sh_valid[1][s] = 1'b0;
      sh_lru[s]      = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    start_test("first_miss");
    check_value("reset rom_abort", 64'(0), 64'(rom_abort));
    check_value("reset dram_req", 64'(0), 64'(dram_req));
    fetch(make_addr(53'h1_2345, 9, 2));
    check_value("first_miss one dram_req", 64'(1), 64'(dram_rises));
    finish_test();

    start_test("line_words");
    for (int i = 0; i < 4; i++) begin
      fetch(make_addr(53'h1_2345, 9, i));
    end
    finish_test();

    start_test("two_tags");
    fetch(make_addr(53'h2_0777, 9, 1));
    fetch(make_addr(53'h1_2345, 9, 3));
    fetch(make_addr(53'h2_0777, 9, 0));
    finish_test();

    // tags a, b, a, c, a, b in set 20
    start_test("lru_replace");
    fetch(make_addr(53'h100, 20, 0));
    fetch(make_addr(53'h200, 20, 1));
    fetch(make_addr(53'h100, 20, 2));
    fetch(make_addr(53'h300, 20, 3));
    fetch(make_addr(53'h100, 20, 0));
    fetch(make_addr(53'h200, 20, 1));
    finish_test();

    start_test("back_to_back");
    for (int i = 0; i < 4; i++) begin
      fetch(make_addr(53'h400, 30 + i, 0));
    end
    for (int i = 0; i < 8; i++) begin
      fetch(make_addr(53'h400, 30 + (i % 4), (i * 3) % 4));
    end
    finish_test();

    start_test("random_mix");
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      fetch(make_addr({r[1:0], 51'h2a5}, 40 + r[3:2], r[5:4]));
    end
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== i_cache.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_refill.sv
rtl/i_cache.sv
testbench/dram_model.sv
testbench/tb_i_cache.sv

// ==== Bender.yml ====
package:
  name: i_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_tag_array.sv
      - rtl/icache_data_array.sv
      - rtl/icache_refill.sv
      - rtl/i_cache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/dram_model.sv
      - testbench/tb_i_cache.sv
